// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_core
BUILD_DIR ?= obj_dir
FILELIST  ?= filelist.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bus_fabric.sv
module bus_fabric
  import core_isa_pkg::*;
  import bus_pkg::*;
(
  input  logic              clock,
  input  logic              reset,
  mem_bus_if.responder      fetch_bus,
  mem_bus_if.responder      lsu_bus,
  mem_bus_if.requester      timer_bus,
  output logic              master_arvalid,
  input  logic              master_arready,
  output word_t             master_araddr,
  input  logic              master_rvalid,
  output logic              master_rready,
  input  word_t             master_rdata,
  input  logic [1:0]        master_rresp,
  output logic              master_awvalid,
  input  logic              master_awready,
  output word_t             master_awaddr,
  output logic              master_wvalid,
  input  logic              master_wready,
  output word_t             master_wdata,
  output logic [XLEN/8-1:0] master_wstrb,
  input  logic              master_bvalid,
  output logic              master_bready,
  input  logic [1:0]        master_bresp
);

  typedef enum logic [1:0] {own_none, own_fetch, own_lsu} owner_e;

  owner_e owner;
  logic   to_timer;
  logic   sel_fetch;
  logic   sel_lsu;
  logic   sel_arvalid;
  logic   sel_arready;
  logic   sel_rvalid;
  logic   sel_rready;
  word_t  sel_araddr;
  word_t  sel_rdata;
  resp_e  sel_rresp;
  logic   resp_done;

  function automatic logic in_timer(word_t a);
    return (a & CLINT_MASK) == CLINT_BASE;
  endfunction

  // load/store wins a tie, grant held until the response
  always_ff @(posedge clock) begin
    if (reset) begin
      owner    <= own_none;
      to_timer <= 1'b0;
    end else if (owner == own_none) begin
      if (lsu_bus.arvalid || lsu_bus.awvalid) begin
        owner    <= own_lsu;
        to_timer <= lsu_bus.arvalid && in_timer(lsu_bus.araddr);
      end else if (fetch_bus.arvalid) begin
        owner    <= own_fetch;
        to_timer <= in_timer(fetch_bus.araddr);
      end
    end else if (resp_done) begin
      owner <= own_none;
    end
  end

  assign sel_fetch   = (owner == own_fetch);
  assign sel_lsu     = (owner == own_lsu);
  assign sel_arvalid = (sel_fetch && fetch_bus.arvalid) || (sel_lsu && lsu_bus.arvalid);
  assign sel_rready  = (sel_fetch && fetch_bus.rready) || (sel_lsu && lsu_bus.rready);
  assign sel_araddr  = sel_fetch ? fetch_bus.araddr : lsu_bus.araddr;

  // read routing by the decoded window
  assign master_arvalid    = sel_arvalid && !to_timer;
  assign master_araddr     = sel_araddr;
  assign master_rready     = sel_rready && !to_timer;
  assign timer_bus.arvalid = sel_arvalid && to_timer;
  assign timer_bus.araddr  = sel_araddr;
  assign timer_bus.rready  = sel_rready && to_timer;

  assign sel_arready = to_timer ? timer_bus.arready : master_arready;
  assign sel_rvalid  = to_timer ? timer_bus.rvalid : master_rvalid;
  assign sel_rdata   = to_timer ? timer_bus.rdata : master_rdata;
  assign sel_rresp   = to_timer ? timer_bus.rresp : resp_e'(master_rresp);

  assign fetch_bus.arready = sel_fetch && sel_arready;
  assign fetch_bus.rvalid  = sel_fetch && sel_rvalid;
  assign fetch_bus.rdata   = sel_rdata;
  assign fetch_bus.rresp   = sel_rresp;
  assign lsu_bus.arready   = sel_lsu && sel_arready;
  assign lsu_bus.rvalid    = sel_lsu && sel_rvalid;
  assign lsu_bus.rdata     = sel_rdata;
  assign lsu_bus.rresp     = sel_rresp;

  // writes always leave on the master port
  assign master_awvalid  = sel_lsu && lsu_bus.awvalid;
  assign master_awaddr   = lsu_bus.awaddr;
  assign master_wvalid   = sel_lsu && lsu_bus.wvalid;
  assign master_wdata    = lsu_bus.wdata;
  assign master_wstrb    = lsu_bus.wstrb;
  assign master_bready   = sel_lsu && lsu_bus.bready;
  assign lsu_bus.awready = sel_lsu && master_awready;
  assign lsu_bus.wready  = sel_lsu && master_wready;
  assign lsu_bus.bvalid  = sel_lsu && master_bvalid;
  assign lsu_bus.bresp   = resp_e'(master_bresp);

  assign resp_done = (sel_rvalid && sel_rready) || (master_bvalid && master_bready);

  // unused write halves stay idle
  assign fetch_bus.awready = 1'b0;
  assign fetch_bus.wready  = 1'b0;
  assign fetch_bus.bvalid  = 1'b0;
  assign fetch_bus.bresp   = okay;
  assign timer_bus.awvalid = 1'b0;
  assign timer_bus.awaddr  = '0;
  assign timer_bus.wvalid  = 1'b0;
  assign timer_bus.wdata   = '0;
  assign timer_bus.wstrb   = '0;
  assign timer_bus.bready  = 1'b0;

endmodule

// File: bus_pkg.sv
package bus_pkg;

  typedef logic [31:0] word_t;

  typedef enum logic [1:0] {
    okay   = 2'b00,
    slverr = 2'b10
  } resp_e;

  // timer window, reads only
  localparam word_t CLINT_BASE = 32'h0200_0000;
  localparam word_t CLINT_MASK = 32'hffff_0000;

endpackage

// File: clint_timer.sv
module clint_timer
  import core_isa_pkg::*;
  import bus_pkg::*;
(
  input  logic         clock,
  input  logic         reset,
  mem_bus_if.responder bus
);

  logic [2*XLEN-1:0] mtime;
  logic              rvalid_q;
  word_t             rdata_q;
  resp_e             rresp_q;
  word_t             offset;

  assign offset = bus.araddr & ~CLINT_MASK;

  always_ff @(posedge clock) begin
    if (reset) begin
      mtime    <= '0;
      rvalid_q <= 1'b0;
    end else begin
      mtime <= mtime + 1'b1;
      if (bus.arvalid && bus.arready) begin
        rvalid_q <= 1'b1;
      end else if (rvalid_q && bus.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // low word at 0, high word at 4
  always_ff @(posedge clock) begin
    if (bus.arvalid && bus.arready) begin
      case (offset)
        32'h0: begin
          rdata_q <= mtime[XLEN-1:0];
          rresp_q <= okay;
        end
        32'h4: begin
          rdata_q <= mtime[2*XLEN-1:XLEN];
          rresp_q <= okay;
        end
        default: begin
          rdata_q <= '0;
          rresp_q <= slverr;
        end
      endcase
    end
  end

  // accepts right away unless a response is still pending
  assign bus.arready = !rvalid_q;
  assign bus.rvalid  = rvalid_q;
  assign bus.rdata   = rdata_q;
  assign bus.rresp   = rresp_q;

  assign bus.awready = 1'b0;
  assign bus.wready  = 1'b0;
  assign bus.bvalid  = 1'b0;
  assign bus.bresp   = okay;

endmodule

// File: core_isa_pkg.sv
package core_isa_pkg;

  localparam int XLEN = 32;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    lui    = 7'b0110111,
    op_imm = 7'b0010011,
    op     = 7'b0110011,
    load   = 7'b0000011,
    store  = 7'b0100011,
    branch = 7'b1100011,
    system = 7'b1110011
  } opcode_e;

  typedef enum logic [1:0] {
    add,
    sub,
    pass_b
  } alu_op_e;

  // immediates, sign extended to XLEN
  function automatic logic [XLEN-1:0] imm_i(logic [XLEN-1:0] inst);
    return {{20{inst[31]}}, inst[31:20]};
  endfunction

  function automatic logic [XLEN-1:0] imm_s(logic [XLEN-1:0] inst);
    return {{20{inst[31]}}, inst[31:25], inst[11:7]};
  endfunction

  function automatic logic [XLEN-1:0] imm_b(logic [XLEN-1:0] inst);
    return {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  endfunction

  function automatic logic [XLEN-1:0] imm_u(logic [XLEN-1:0] inst);
    return {inst[31:12], 12'b0};
  endfunction

endpackage

// File: exec_unit.sv
module exec_unit
  import core_isa_pkg::*;
  import bus_pkg::*;
(
  input  logic  clock,
  input  logic  reset,
  input  word_t inst,
  input  logic  inst_valid,
  input  word_t pc,
  output logic  mem_req,
  output logic  mem_write,
  output word_t mem_addr,
  output word_t mem_wdata,
  input  logic  mem_done,
  input  word_t mem_rdata,
  output word_t next_pc,
  output logic  retire,
  output logic  halted
);

  typedef enum logic [1:0] {idle, execute, wait_mem, done} state_e;

  state_e          state;
  logic [XLEN-1:0] rf [16];
  opcode_e         opc;
  alu_op_e         alu_op;
  logic [3:0]      rd;
  logic [3:0]      rs1;
  logic [3:0]      rs2;
  word_t           src1;
  word_t           src2;
  word_t           alu_b;
  word_t           alu_result;
  logic            writes_rd;
  logic            taken;
  logic            ebreak;

  assign opc = opcode_e'(inst[6:0]);
  // RV32E, only the low four index bits matter
  assign rd  = inst[10:7];
  assign rs1 = inst[18:15];
  assign rs2 = inst[23:20];

  // x0 reads as zero
  assign src1 = (rs1 == 4'd0) ? '0 : rf[rs1];
  assign src2 = (rs2 == 4'd0) ? '0 : rf[rs2];

  always_comb begin
    alu_op    = add;
    alu_b     = src2;
    writes_rd = 1'b0;
    case (opc)
      lui: begin
        alu_op    = pass_b;
        alu_b     = imm_u(inst);
        writes_rd = 1'b1;
      end
      op_imm: begin
        alu_b     = imm_i(inst);
        writes_rd = 1'b1;
      end
      op: begin
        alu_op    = inst[30] ? sub : add;
        writes_rd = 1'b1;
      end
      load:    alu_b = imm_i(inst);
      store:   alu_b = imm_s(inst);
      branch:  alu_op = sub;
      default: alu_b = src2;
    endcase
  end

  always_comb begin
    case (alu_op)
      sub:     alu_result = src1 - alu_b;
      pass_b:  alu_result = alu_b;
      default: alu_result = src1 + alu_b;
    endcase
  end

  // only BEQ is decoded among the branches
  assign taken  = (opc == branch) && (inst[14:12] == 3'b000) && (alu_result == '0);
  assign ebreak = (opc == system) && (inst[31:20] == 12'd1);

  assign mem_req   = (state == execute) && ((opc == load) || (opc == store));
  assign mem_write = (opc == store);
  assign mem_addr  = alu_result;
  assign mem_wdata = src2;
  assign retire    = (state == done);

  always_ff @(posedge clock) begin
    if (reset) begin
      state  <= idle;
      halted <= 1'b0;
    end else begin
      case (state)
        idle: if (inst_valid && !halted) state <= execute;
        execute: begin
          if (ebreak) begin
            halted <= 1'b1;
            state  <= idle;
          end else if (mem_req) begin
            state <= wait_mem;
          end else begin
            state <= done;
          end
        end
        wait_mem: if (mem_done) state <= done;
        default:  state <= idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == execute) begin
      next_pc <= taken ? pc + imm_b(inst) : pc + 32'd4;
      if (writes_rd) begin
        rf[rd] <= alu_result;
      end
    end
    if (state == wait_mem && mem_done && opc == load) begin
      rf[rd] <= mem_rdata;
    end
  end

endmodule

// File: fetch_unit.sv
module fetch_unit
  import core_isa_pkg::*;
  import bus_pkg::*;
#(
  parameter logic [XLEN-1:0] RESET_VECTOR = 32'h0000_0000
) (
  input  logic         clock,
  input  logic         reset,
  mem_bus_if.requester bus,
  input  word_t        next_pc,
  input  logic         retire,
  output word_t        inst,
  output logic         inst_valid,
  output word_t        pc,
  input  logic         halted
);

  typedef enum logic [1:0] {f_boot, f_addr, f_data, f_wait} state_e;

  state_e state;

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= f_boot;
      inst_valid <= 1'b0;
      pc         <= RESET_VECTOR;
    end else begin
      inst_valid <= 1'b0;
      if (retire) begin
        pc <= next_pc;
      end
      case (state)
        f_boot: if (!halted) state <= f_addr;
        f_addr: if (bus.arready) state <= f_data;
        f_data: begin
          if (bus.rvalid) begin
            state      <= f_wait;
            inst_valid <= 1'b1;
          end
        end
        // next fetch starts the cycle after retire
        f_wait: if (retire && !halted) state <= f_addr;
        default: state <= f_boot;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == f_data && bus.rvalid) begin
      inst <= bus.rdata;
    end
  end

  assign bus.arvalid = (state == f_addr);
  assign bus.araddr  = pc;
  assign bus.rready  = (state == f_data);

  // instruction side never writes
  assign bus.awvalid = 1'b0;
  assign bus.awaddr  = '0;
  assign bus.wvalid  = 1'b0;
  assign bus.wdata   = '0;
  assign bus.wstrb   = '0;
  assign bus.bready  = 1'b0;

endmodule

// File: filelist.f
core_isa_pkg.sv
bus_pkg.sv
mem_bus_if.sv
fetch_unit.sv
exec_unit.sv
load_store_unit.sv
bus_fabric.sv
clint_timer.sv
riscv_core_top.sv
tb_core.sv

// File: load_store_unit.sv
module load_store_unit
  import core_isa_pkg::*;
  import bus_pkg::*;
(
  input  logic         clock,
  input  logic         reset,
  input  logic         req,
  input  logic         write,
  input  word_t        addr,
  input  word_t        wdata,
  output logic         done,
  output word_t        rdata,
  mem_bus_if.requester bus
);

  typedef enum logic [1:0] {ls_idle, ls_addr, ls_resp} state_e;

  state_e state;
  logic   is_write;
  logic   aw_pend;
  logic   w_pend;
  word_t  addr_q;
  word_t  wdata_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      state   <= ls_idle;
      aw_pend <= 1'b0;
      w_pend  <= 1'b0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        ls_idle: begin
          if (req) begin
            state   <= ls_addr;
            aw_pend <= write;
            w_pend  <= write;
          end
        end
        ls_addr: begin
          if (is_write) begin
            // address and data may be taken in different cycles
            if (bus.awready) aw_pend <= 1'b0;
            if (bus.wready) w_pend <= 1'b0;
            if ((!aw_pend || bus.awready) && (!w_pend || bus.wready)) state <= ls_resp;
          end else if (bus.arready) begin
            state <= ls_resp;
          end
        end
        ls_resp: begin
          if (is_write ? bus.bvalid : bus.rvalid) begin
            done  <= 1'b1;
            state <= ls_idle;
          end
        end
        default: state <= ls_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == ls_idle && req) begin
      is_write <= write;
      addr_q   <= addr;
      wdata_q  <= wdata;
    end
    if (state == ls_resp && !is_write && bus.rvalid) begin
      rdata <= bus.rdata;
    end
  end

  assign bus.arvalid = (state == ls_addr) && !is_write;
  assign bus.araddr  = addr_q;
  assign bus.rready  = (state == ls_resp) && !is_write;
  assign bus.awvalid = aw_pend;
  assign bus.awaddr  = addr_q;
  assign bus.wvalid  = w_pend;
  assign bus.wdata   = wdata_q;
  // word access only
  assign bus.wstrb   = {(XLEN/8){1'b1}};
  assign bus.bready  = (state == ls_resp) && is_write;

endmodule

// File: mem_bus_if.sv
interface mem_bus_if
  import core_isa_pkg::*;
  import bus_pkg::*;
();

  // read channel
  logic             arvalid;
  logic             arready;
  word_t            araddr;
  logic             rvalid;
  logic             rready;
  word_t            rdata;
  resp_e            rresp;

  // write channel
  logic             awvalid;
  logic             awready;
  word_t            awaddr;
  logic             wvalid;
  logic             wready;
  word_t            wdata;
  logic [XLEN/8-1:0] wstrb;
  logic             bvalid;
  logic             bready;
  resp_e            bresp;

  modport requester (
    output arvalid, araddr, rready, awvalid, awaddr, wvalid, wdata, wstrb, bready,
    input  arready, rvalid, rdata, rresp, awready, wready, bvalid, bresp
  );

  modport responder (
    input  arvalid, araddr, rready, awvalid, awaddr, wvalid, wdata, wstrb, bready,
    output arready, rvalid, rdata, rresp, awready, wready, bvalid, bresp
  );

endinterface

// File: riscv_core_top.sv
module riscv_core_top
  import core_isa_pkg::*;
  import bus_pkg::*;
#(
  parameter logic [XLEN-1:0] RESET_VECTOR = 32'h8000_0000
) (
  input  logic              clock,
  input  logic              reset,
  output logic              halted,
  output logic              master_arvalid,
  input  logic              master_arready,
  output logic [XLEN-1:0]   master_araddr,
  input  logic              master_rvalid,
  output logic              master_rready,
  input  logic [XLEN-1:0]   master_rdata,
  input  logic [1:0]        master_rresp,
  output logic              master_awvalid,
  input  logic              master_awready,
  output logic [XLEN-1:0]   master_awaddr,
  output logic              master_wvalid,
  input  logic              master_wready,
  output logic [XLEN-1:0]   master_wdata,
  output logic [XLEN/8-1:0] master_wstrb,
  input  logic              master_bvalid,
  output logic              master_bready,
  input  logic [1:0]        master_bresp
);

  word_t inst;
  word_t pc;
  word_t next_pc;
  logic  inst_valid;
  logic  retire;
  logic  mem_req;
  logic  mem_write;
  word_t mem_addr;
  word_t mem_wdata;
  logic  mem_done;
  word_t mem_rdata;

  mem_bus_if fetch_bus ();
  mem_bus_if lsu_bus ();
  mem_bus_if timer_bus ();

  fetch_unit #(
    .RESET_VECTOR(RESET_VECTOR)
  ) u_fetch (
    .clock      (clock),
    .reset      (reset),
    .bus        (fetch_bus.requester),
    .next_pc    (next_pc),
    .retire     (retire),
    .inst       (inst),
    .inst_valid (inst_valid),
    .pc         (pc),
    .halted     (halted)
  );

  exec_unit u_exec (
    .clock      (clock),
    .reset      (reset),
    .inst       (inst),
    .inst_valid (inst_valid),
    .pc         (pc),
    .mem_req    (mem_req),
    .mem_write  (mem_write),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_done   (mem_done),
    .mem_rdata  (mem_rdata),
    .next_pc    (next_pc),
    .retire     (retire),
    .halted     (halted)
  );

  load_store_unit u_lsu (
    .clock (clock),
    .reset (reset),
    .req   (mem_req),
    .write (mem_write),
    .addr  (mem_addr),
    .wdata (mem_wdata),
    .done  (mem_done),
    .rdata (mem_rdata),
    .bus   (lsu_bus.requester)
  );

  bus_fabric u_fabric (
    .clock          (clock),
    .reset          (reset),
    .fetch_bus      (fetch_bus.responder),
    .lsu_bus        (lsu_bus.responder),
    .timer_bus      (timer_bus.requester),
    .master_arvalid (master_arvalid),
    .master_arready (master_arready),
    .master_araddr  (master_araddr),
    .master_rvalid  (master_rvalid),
    .master_rready  (master_rready),
    .master_rdata   (master_rdata),
    .master_rresp   (master_rresp),
    .master_awvalid (master_awvalid),
    .master_awready (master_awready),
    .master_awaddr  (master_awaddr),
    .master_wvalid  (master_wvalid),
    .master_wready  (master_wready),
    .master_wdata   (master_wdata),
    .master_wstrb   (master_wstrb),
    .master_bvalid  (master_bvalid),
    .master_bready  (master_bready),
    .master_bresp   (master_bresp)
  );

  clint_timer u_timer (
    .clock (clock),
    .reset (reset),
    .bus   (timer_bus.responder)
  );

endmodule

// File: tb_core.sv
module tb_core
  import core_isa_pkg::*;
  import bus_pkg::*;
();

  localparam word_t MEM_BASE = 32'h8000_0000;
  localparam word_t DATA_BASE = 32'h8000_1000;
  localparam int MEM_WORDS = 2048;
  localparam int PROG_LEN = 27;
  localparam int DELAY_FACTOR = 4;

  logic clock;
  logic reset;
  logic halted;
  logic master_arvalid;
  logic master_arready;
  word_t master_araddr;
  logic master_rvalid;
  logic master_rready;
  word_t master_rdata;
  logic [1:0] master_rresp;
  logic master_awvalid;
  logic master_awready;
  word_t master_awaddr;
  logic master_wvalid;
  logic master_wready;
  word_t master_wdata;
  logic [3:0] master_wstrb;
  logic master_bvalid;
  logic master_bready;
  logic [1:0] master_bresp;

  word_t mem [MEM_WORDS];
  word_t ref_mem [MEM_WORDS];
  logic ref_dc [MEM_WORDS];
  word_t exp_addr [$];
  word_t exp_data [$];
  logic exp_dc [$];
  int errors;
  int store_idx;
  int ref_count;
  word_t timer_lo0;
  word_t timer_lo1;
  logic [1:0] timer_seen;
  logic halt_seen;

  logic [2:0] rd_state;
  logic [1:0] rd_wait;
  word_t rd_addr;
  logic [2:0] wr_state;
  logic [1:0] wr_wait;
  word_t wr_addr;
  word_t wr_data;

  riscv_core_top #(
    .RESET_VECTOR(32'h8000_0000)
  ) uut (
    .clock          (clock),
    .reset          (reset),
    .halted         (halted),
    .master_arvalid (master_arvalid),
    .master_arready (master_arready),
    .master_araddr  (master_araddr),
    .master_rvalid  (master_rvalid),
    .master_rready  (master_rready),
    .master_rdata   (master_rdata),
    .master_rresp   (master_rresp),
    .master_awvalid (master_awvalid),
    .master_awready (master_awready),
    .master_awaddr  (master_awaddr),
    .master_wvalid  (master_wvalid),
    .master_wready  (master_wready),
    .master_wdata   (master_wdata),
    .master_wstrb   (master_wstrb),
    .master_bvalid  (master_bvalid),
    .master_bready  (master_bready),
    .master_bresp   (master_bresp)
  );

  task automatic check_value(string name, word_t got, word_t expected);
    if (got !== expected) begin
      errors++;
      $display("Fail %s: got %h expected %h", name, got, expected);
    end
  endtask

  task automatic report(string what);
    errors++;
    $display("error: %s", what);
  endtask

  // instruction encoders
  function automatic word_t enc_u(logic [4:0] rd, logic [19:0] imm);
    return {imm, rd, lui};
  endfunction

  function automatic word_t enc_i(opcode_e opc, logic [2:0] f3, logic [4:0] rd,
                                  logic [4:0] rs1, word_t imm);
    return {imm[11:0], rs1, f3, rd, opc};
  endfunction

  function automatic word_t enc_r(logic [6:0] f7, logic [4:0] rd, logic [4:0] rs1,
                                  logic [4:0] rs2);
    return {f7, rs2, rs1, 3'b000, rd, op};
  endfunction

  function automatic word_t enc_s(logic [4:0] rs2, logic [4:0] rs1, word_t imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], store};
  endfunction

  function automatic word_t enc_b(logic [4:0] rs1, logic [4:0] rs2, word_t imm);
    return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], branch};
  endfunction

  // background contents, a function of the full address
  function automatic word_t fill_word(word_t a);
    return (a * 32'h0001_0003) ^ 32'h5a5a_0000;
  endfunction

  function automatic logic in_mem(word_t a);
    return a >= MEM_BASE && a < MEM_BASE + MEM_WORDS * 4;
  endfunction

  task automatic load_program();
    word_t p [PROG_LEN];
    p[0]  = enc_u(1, 20'h80001);
    p[1]  = enc_i(op_imm, 3'b000, 2, 0, 123);
    p[2]  = enc_i(op_imm, 3'b000, 3, 0, -45);
    p[3]  = enc_r(7'h00, 4, 2, 3);
    p[4]  = enc_r(7'h20, 5, 2, 3);
    p[5]  = enc_u(6, 20'h12345);
    p[6]  = enc_i(op_imm, 3'b000, 6, 6, 32'h678);
    p[7]  = enc_s(4, 1, 0);
    p[8]  = enc_s(5, 1, 4);
    p[9]  = enc_s(6, 1, 8);
    p[10] = enc_i(load, 3'b010, 7, 1, 64);
    p[11] = enc_s(7, 1, 12);
    p[12] = enc_i(load, 3'b010, 8, 1, 8);
    p[13] = enc_s(8, 1, 16);
    p[14] = enc_b(2, 2, 8);
    p[15] = enc_s(2, 1, 20);
    p[16] = enc_b(2, 3, 8);
    p[17] = enc_s(3, 1, 24);
    p[18] = enc_u(10, 20'h02000);
    p[19] = enc_i(load, 3'b010, 11, 10, 0);
    p[20] = enc_s(2, 1, 28);
    p[21] = enc_s(3, 1, 32);
    p[22] = enc_i(load, 3'b010, 12, 10, 0);
    p[23] = enc_s(11, 1, 36);
    p[24] = enc_s(12, 1, 40);
    p[25] = 32'h0010_0073;
    // must never execute
    p[26] = enc_s(2, 1, 44);
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = fill_word(MEM_BASE + i * 4);
    end
    for (int i = 0; i < PROG_LEN; i++) begin
      mem[i] = p[i];
    end
    for (int i = 0; i < MEM_WORDS; i++) begin
      ref_mem[i] = mem[i];
      ref_dc[i] = 1'b0;
    end
  endtask

  // instruction-level model; timer values are unknown, tracked as taint
  function automatic int run_model();
    word_t r [16];
    logic t [16];
    word_t pc_m;
    word_t w;
    word_t a;
    word_t imm;
    int n;
    int idx;
    n = 0;
    pc_m = MEM_BASE;
    for (int i = 0; i < 16; i++) begin
      r[i] = '0;
      t[i] = 1'b0;
    end
    while (n < 1000) begin
      w = ref_mem[(pc_m - MEM_BASE) >> 2];
      n++;
      if (w == 32'h0010_0073) break;
      case (w[6:0])
        7'b0110111: begin
          r[w[10:7]] = {w[31:12], 12'h000};
          t[w[10:7]] = 1'b0;
        end
        7'b0010011: begin
          r[w[10:7]] = r[w[18:15]] + {{20{w[31]}}, w[31:20]};
          t[w[10:7]] = t[w[18:15]];
        end
        7'b0110011: begin
          r[w[10:7]] = w[30] ? r[w[18:15]] - r[w[23:20]] : r[w[18:15]] + r[w[23:20]];
          t[w[10:7]] = t[w[18:15]] | t[w[23:20]];
        end
        7'b0000011: begin
          a = r[w[18:15]] + {{20{w[31]}}, w[31:20]};
          idx = (a - MEM_BASE) >> 2;
          if ((a & CLINT_MASK) == CLINT_BASE) begin
            r[w[10:7]] = '0;
            t[w[10:7]] = 1'b1;
          end else begin
            r[w[10:7]] = in_mem(a) ? ref_mem[idx] : fill_word(a);
            t[w[10:7]] = in_mem(a) ? ref_dc[idx] : 1'b0;
          end
        end
        7'b0100011: begin
          a = r[w[18:15]] + {{20{w[31]}}, w[31:25], w[11:7]};
          exp_addr.push_back(a);
          exp_data.push_back(r[w[23:20]]);
          exp_dc.push_back(t[w[23:20]]);
          if (in_mem(a)) begin
            ref_mem[(a - MEM_BASE) >> 2] = r[w[23:20]];
            ref_dc[(a - MEM_BASE) >> 2] = t[w[23:20]];
          end
        end
        default: ;
      endcase
      imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      if (w[6:0] == 7'b1100011 && w[14:12] == 3'b000 && r[w[18:15]] == r[w[23:20]]) begin
        pc_m = pc_m + imm;
      end else begin
        pc_m = pc_m + 4;
      end
      r[0] = '0;
      t[0] = 1'b0;
    end
    return n;
  endfunction

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // read side of the memory model
  always @(posedge clock) begin
    if (reset) begin
      rd_state <= 0;
      master_arready <= 1'b0;
      master_rvalid <= 1'b0;
    end else begin
      case (rd_state)
        0: begin
          if (master_arvalid) begin
            if ((master_araddr & CLINT_MASK) == CLINT_BASE) begin
              report("timer window read seen on the master port");
            end
            rd_wait <= 2'($urandom % 4);
            rd_state <= 1;
          end
        end
        1: begin
          if (rd_wait == 0) begin
            master_arready <= 1'b1;
            rd_state <= 2;
          end else begin
            rd_wait <= rd_wait - 1;
          end
        end
        2: begin
          master_arready <= 1'b0;
          rd_addr <= master_araddr;
          rd_wait <= 2'($urandom % 4);
          rd_state <= 3;
        end
        3: begin
          if (rd_wait == 0) begin
            master_rvalid <= 1'b1;
            master_rdata <= in_mem(rd_addr) ? mem[(rd_addr - MEM_BASE) >> 2]
                                            : fill_word(rd_addr);
            rd_state <= 4;
          end else begin
            rd_wait <= rd_wait - 1;
          end
        end
        default: begin
          if (master_rready) begin
            master_rvalid <= 1'b0;
            rd_state <= 0;
          end
        end
      endcase
    end
  end

  // write side, compares each store against the model as it lands
  always @(posedge clock) begin
    if (reset) begin
      wr_state <= 0;
      master_awready <= 1'b0;
      master_wready <= 1'b0;
      master_bvalid <= 1'b0;
    end else begin
      case (wr_state)
        0: begin
          if (master_awvalid && master_wvalid) begin
            wr_addr <= master_awaddr;
            wr_data <= master_wdata;
            wr_wait <= 2'($urandom % 4);
            wr_state <= 1;
          end
        end
        1, 2: begin
          if (!master_awvalid || !master_wvalid) begin
            report("write valid dropped before the handshake");
          end
          check_value("master_awaddr", master_awaddr, wr_addr);
          check_value("master_wdata", master_wdata, wr_data);
          // word stores enable all byte lanes
          check_value("master_wstrb", {28'h0, master_wstrb}, 32'h0000_000f);
          if (wr_state == 1) begin
            if (wr_wait == 0) begin
              master_awready <= 1'b1;
              master_wready <= 1'b1;
              wr_state <= 2;
            end else begin
              wr_wait <= wr_wait - 1;
            end
          end else begin
            master_awready <= 1'b0;
            master_wready <= 1'b0;
            if (in_mem(wr_addr)) begin
              mem[(wr_addr - MEM_BASE) >> 2] <= wr_data;
            end
            if (store_idx < exp_addr.size()) begin
              check_value("store awaddr", wr_addr, exp_addr[store_idx]);
              if (!exp_dc[store_idx]) begin
                check_value("store wdata", wr_data, exp_data[store_idx]);
              end
            end else begin
              report("store beyond the expected sequence");
            end
            if (wr_addr == DATA_BASE + 36) begin
              timer_lo0 <= wr_data;
              timer_seen[0] <= 1'b1;
            end
            if (wr_addr == DATA_BASE + 40) begin
              timer_lo1 <= wr_data;
              timer_seen[1] <= 1'b1;
            end
            store_idx <= store_idx + 1;
            wr_wait <= 2'($urandom % 4);
            wr_state <= 3;
          end
        end
        3: begin
          if (wr_wait == 0) begin
            master_bvalid <= 1'b1;
            wr_state <= 4;
          end else begin
            wr_wait <= wr_wait - 1;
          end
        end
        default: begin
          if (master_bready) begin
            master_bvalid <= 1'b0;
            wr_state <= 0;
          end
        end
      endcase
    end
  end

  // halt stays put and the port goes quiet
  always @(posedge clock) begin
    if (reset) begin
      halt_seen <= 1'b0;
    end else begin
      if (halt_seen && !halted) report("halted dropped before reset");
      if (halt_seen && (master_arvalid || master_awvalid || master_wvalid)) begin
        report("bus valid raised after halt");
      end
      if (halted) halt_seen <= 1'b1;
    end
  end

  initial begin
    repeat (200 * PROG_LEN * DELAY_FACTOR) @(posedge clock);
    $display("timeout: the core did not halt in time");
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    word_t seed;
    seed = $urandom(32'h3f13);
    errors = 0;
    store_idx = 0;
    timer_seen = 2'b00;
    timer_lo0 = '0;
    timer_lo1 = '0;
    reset = 1'b1;
    master_arready = 1'b0;
    master_rvalid = 1'b0;
    master_rdata = '0;
    master_rresp = 2'b00;
    master_awready = 1'b0;
    master_wready = 1'b0;
    master_bvalid = 1'b0;
    master_bresp = 2'b00;
    load_program();
    ref_count = run_model();
    repeat (3) @(posedge clock);
    reset <= 1'b0;
    while (!halted) @(posedge clock);
    repeat (20) @(posedge clock);
    check_value("store count", store_idx, exp_addr.size());
    for (int i = 1024; i < MEM_WORDS; i++) begin
      if (!ref_dc[i]) begin
        check_value($sformatf("mem[%h]", MEM_BASE + i * 4), mem[i], ref_mem[i]);
      end
    end
    if (timer_seen != 2'b11) begin
      report("timer values were not stored");
    end else if (timer_lo1 <= timer_lo0) begin
      report($sformatf("timer did not advance, %h then %h", timer_lo0, timer_lo1));
    end
    $display("errors: %0d, model instructions: %0d", errors, ref_count);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
